// File: tests/zxuno_memsys_tests.txt
# op addr data expect name
# op: P port write, W mem write, R mem read, I io read, V video read (addr = vid_addr)
R 0012 00 12 rom_rd_sel0
R 3FA7 00 A7 rom_rd_sel0_top
P 7FFD 10 00 port_rom1
R 0012 00 47 rom_rd_sel1
R 3FA7 00 F2 rom_rd_sel1_top
W 4000 A5 00 wr_4000
R 4000 00 A5 rd_4000
W 8123 3C 00 wr_8123
R 8123 00 3C rd_8123
P 7FFD 00 00 port_bank0
W C010 11 00 wr_c010_bank0
P 7FFD 03 00 port_bank3
W C010 33 00 wr_c010_bank3
R C010 00 33 rd_c010_bank3
P 7FFD 00 00 port_bank0_again
R C010 00 11 rd_c010_bank0
P 7FFD 05 00 port_bank5
W C200 5E 00 wr_c200_bank5
R 4200 00 5E rd_4200_alias
V 0000 00 A5 vid_bank5
P 7FFD 07 00 port_bank7
W C000 7E 00 wr_c000_bank7
V 0000 00 A5 vid_still_bank5
P 7FFD 0F 00 port_vram1
V 0000 00 7E vid_bank7
P 7FFD 33 00 port_lock
R 0012 00 47 rom_locked_sel1
P 7FFD 00 00 port_ignored
R 0012 00 47 rom_still_sel1
R C010 00 33 rd_c010_locked_bank3
V 0000 00 A5 vid_after_lock
I 00FE 00 FF io_read_fe
I 7FFD 00 FF io_read_port

// File: zxuno_memsys.f
+incdir+include
logic/zxuno_pkg.sv
logic/page_mapper.sv
logic/sram_arbiter.sv
logic/cpu_data_mux.sv
logic/zxuno_memsys.sv
tests/sram_model.sv
tests/zxuno_memsys_tb.sv

// File: Bender.yml
package:
  name: zxuno_memsys

export_include_dirs:
  - include

sources:
  - logic/zxuno_pkg.sv
  - logic/page_mapper.sv
  - logic/sram_arbiter.sv
  - logic/cpu_data_mux.sv
  - logic/zxuno_memsys.sv
  - target: test
    files:
      - tests/sram_model.sv
      - tests/zxuno_memsys_tb.sv

// File: tests/zxuno_memsys_tb.sv
`include "zxuno_settings.svh"

module zxuno_memsys_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_NS       = 8;
  localparam int RESET_CYCLES = 4;
  localparam int HOLD_CYCLES  = 4;  // Strobe length per operation

  logic                   clk;
  logic                   rst_n;
  zxuno_pkg::cpu_bus_t    cpu;
  logic [7:0]             rom_data;
  logic [13:0]            vid_addr;
  logic [7:0]             cpu_din;
  logic [14:0]            rom_addr;
  logic [7:0]             vid_data;
  logic [`ZX_SRAM_AW-1:0] sram_addr;
  logic                   sram_we_n;
  wire  [7:0]             sram_data;

  // Operation table from the data file
  string       op_q[$];
  logic [15:0] addr_q[$];
  logic [7:0]  data_q[$];
  logic [7:0]  exp_q[$];
  string       name_q[$];

  bit                   loaded;
  int                   n_checks;
  zxuno_pkg::page_cfg_t cfg_model;  // Expected paging state

  zxuno_memsys zxuno_memsys_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu       (cpu),
    .rom_data  (rom_data),
    .vid_addr  (vid_addr),
    .cpu_din   (cpu_din),
    .rom_addr  (rom_addr),
    .vid_data  (vid_data),
    .sram_addr (sram_addr),
    .sram_we_n (sram_we_n),
    .sram_data (sram_data)
  );

  sram_model sram_model_inst (
    .addr (sram_addr),
    .we_n (sram_we_n),
    .data (sram_data)
  );

  // Second ROM is the first one XOR 0x55
  function automatic logic [7:0] rom_byte(input logic [14:0] a);
    return a[7:0] ^ (a[14] ? 8'h55 : 8'h00);
  endfunction

  assign rom_data = rom_byte(rom_addr);

  function automatic zxuno_pkg::cpu_bus_t idle_bus();
    zxuno_pkg::cpu_bus_t b;
    b        = '0;
    b.mreq_n = 1'b1;
    b.iorq_n = 1'b1;
    b.rd_n   = 1'b1;
    b.wr_n   = 1'b1;
    return b;
  endfunction

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_NS / 2) clk = ~clk;
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    n_checks++;
    if (act !== exp) begin
      $display("** Error: %s expected %02h actual %02h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic check_rom_addr(input string name, input logic [14:0] exp,
                                input logic [14:0] act);
    n_checks++;
    if (act !== exp) begin
      $display("** Error: %s expected rom_addr %04h actual %04h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic stop_on(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "Run aborted");
  endtask

  ////////////////////////////////////////
  // Data file reader
  ////////////////////////////////////////
  task automatic load_tests();
    int          fd;
    int          cnt;
    string       line;
    string       op;
    string       name;
    logic [15:0] a;
    logic [7:0]  d;
    logic [7:0]  e;
    fd = $fopen("tests/zxuno_memsys_tests.txt", "r");
    if (fd == 0) begin
      stop_on("Could not open tests/zxuno_memsys_tests.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") begin
        continue;  // Blank or comment
      end
      cnt = $sscanf(line, "%s %h %h %h %s", op, a, d, e, name);
      if (cnt != 5) begin
        stop_on({"Malformed line in the test data file: ", line});
      end
      op_q.push_back(op);
      addr_q.push_back(a);
      data_q.push_back(d);
      exp_q.push_back(e);
      name_q.push_back(name);
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////
  // One bus operation
  ////////////////////////////////////////
  task automatic run_op(input string op, input logic [15:0] a, input logic [7:0] d,
                        input logic [7:0] e, input string name);
    zxuno_pkg::cpu_bus_t b;
    b      = idle_bus();
    b.addr = a;
    b.dout = d;
    if (op == "P") begin
      b.iorq_n = 1'b0;
      b.wr_n   = 1'b0;
    end else if (op == "W") begin
      b.mreq_n = 1'b0;
      b.wr_n   = 1'b0;
    end else if (op == "R") begin
      b.mreq_n = 1'b0;
      b.rd_n   = 1'b0;
    end else if (op == "I") begin
      b.iorq_n = 1'b0;
      b.rd_n   = 1'b0;
    end else if (op != "V") begin
      stop_on({"Unknown operation letter in test ", name});
    end
    @(posedge clk);
    #1;
    cpu = b;
    if (op == "V") begin
      vid_addr = a[13:0];
    end
    repeat (HOLD_CYCLES - 1) @(posedge clk);
    #(CLK_NS / 2);  // Middle of the last held cycle
    if (op == "P") begin
      if (!cfg_model.lock) begin  // Locked port ignores writes
        cfg_model.bank      = d[2:0];  // Port 0x7FFD bits D2..D0
        cfg_model.vram_page = d[3];
        cfg_model.rom_sel   = d[4];
        cfg_model.lock      = d[5];
      end
      $display("%s: bank %0d vram %0d rom %0d lock %0d", name, cfg_model.bank,
               cfg_model.vram_page, cfg_model.rom_sel, cfg_model.lock);
      check_rom_addr(name, {cfg_model.rom_sel, a[13:0]}, rom_addr);
    end else if (op == "R") begin
      if (a < 16'h4000) begin
        check_rom_addr(name, {cfg_model.rom_sel, a[13:0]}, rom_addr);
      end
      check_byte(name, e, cpu_din);
    end else if (op == "I") begin
      check_byte(name, e, cpu_din);
    end else if (op == "V") begin
      check_byte(name, e, vid_data);
    end
    @(posedge clk);
    #1;
    cpu = idle_bus();  // Idle clk follows in the next call
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    cpu       = idle_bus();
    vid_addr  = '0;
    rst_n     = 1'b0;
    cfg_model = '0;
    n_checks  = 0;
    loaded    = 1'b0;
    load_tests();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    foreach (op_q[i]) begin
      run_op(op_q[i], addr_q[i], data_q[i], exp_q[i], name_q[i]);
    end
    @(posedge clk);
    if (n_checks == 0) begin
      $display("No checks were run");
      $display("TEST FAILED");
      $fatal(1, "Empty test table");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

  // Watchdog sized from the table length
  initial begin
    wait (loaded);
    #((op_q.size() + RESET_CYCLES) * 6 * CLK_NS * 2);
    $display("Timed out before the test sequence finished");
    $display("TEST FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: tests/sram_model.sv
`include "zxuno_settings.svh"

module sram_model (
  input  logic [`ZX_SRAM_AW-1:0] addr,
  input  logic                   we_n,
  inout  wire  [7:0]             data
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH = 1 << `ZX_SRAM_AW;

  logic [7:0] mem [DEPTH];  // 128 KB array

  // Power-up contents follow every address bit
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'(i >> 16);
    end
  end

  ////////////////////////////////////////
  // Asynchronous read
  ////////////////////////////////////////
  assign data = we_n ? mem[addr] : 8'hzz;  // Chip drives only when not written

  ////////////////////////////////////////
  // Write
  ////////////////////////////////////////
  // Latched inside the pulse, after address and data settle
  always @(negedge we_n) begin
    #2;
    if (!we_n) begin
      mem[addr] = data;
    end
  end

endmodule

// File: logic/zxuno_memsys.sv
`include "zxuno_settings.svh"

module zxuno_memsys (
  input  logic                   clk,
  input  logic                   rst_n,
  input  zxuno_pkg::cpu_bus_t    cpu,
  input  logic [7:0]             rom_data,
  input  logic [13:0]            vid_addr,
  output logic [7:0]             cpu_din,
  output logic [14:0]            rom_addr,
  output logic [7:0]             vid_data,
  output logic [`ZX_SRAM_AW-1:0] sram_addr,
  output logic                   sram_we_n,
  inout  wire  [7:0]             sram_data
);

  zxuno_pkg::mem_req_t  mem_req;
  zxuno_pkg::cpu_src_t  cpu_src;
  logic                 vram_bank_hi;
  logic [7:0]           ram_rdata;

  // Port decode and address map
  page_mapper page_mapper_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus          (cpu),
    .cfg          (),
    .rom_addr     (rom_addr),
    .req          (mem_req),
    .src          (cpu_src),
    .vram_bank_hi (vram_bank_hi)
  );

  // SRAM split into video and CPU ports
  sram_arbiter sram_arbiter_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (mem_req),
    .vram_bank_hi (vram_bank_hi),
    .vid_addr     (vid_addr),
    .vid_data     (vid_data),
    .ram_rdata    (ram_rdata),
    .sram_addr    (sram_addr),
    .sram_we_n    (sram_we_n),
    .sram_data    (sram_data)
  );

  cpu_data_mux cpu_data_mux_inst (
    .src       (cpu_src),
    .rom_data  (rom_data),
    .ram_rdata (ram_rdata),
    .cpu_din   (cpu_din)
  );

endmodule

// File: logic/cpu_data_mux.sv
module cpu_data_mux (
  input  zxuno_pkg::cpu_src_t src,
  input  logic [7:0]          rom_data,
  input  logic [7:0]          ram_rdata,
  output logic [7:0]          cpu_din
);

  ////////////////////////////////////////
  // CPU read return
  ////////////////////////////////////////
  // No latching here, data follows the source
  always_comb begin
    case (src)
      zxuno_pkg::SRC_ROM: begin
        cpu_din = rom_data;   // External ROM, async
      end
      zxuno_pkg::SRC_RAM: begin
        cpu_din = ram_rdata;  // Last CPU slot capture
      end
      default: begin
        cpu_din = 8'hFF;      // Floating bus, pulled high
      end
    endcase
  end

endmodule

// File: logic/sram_arbiter.sv
`include "zxuno_settings.svh"

module sram_arbiter (
  input  logic                   clk,
  input  logic                   rst_n,
  input  zxuno_pkg::mem_req_t    req,
  input  logic                   vram_bank_hi,
  input  logic [13:0]            vid_addr,
  output logic [7:0]             vid_data,
  output logic [7:0]             ram_rdata,
  output logic [`ZX_SRAM_AW-1:0] sram_addr,
  output logic                   sram_we_n,
  inout  wire  [7:0]             sram_data
);

  logic       cpu_slot;  // Low for video, high for CPU
  logic       wr_done;   // Current strobe already written
  logic       wr_go;
  logic [2:0] vid_bank;
  logic [7:0] wdata_q;

  ////////////////////////////////////////
  // Slot sequencer
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cpu_slot <= 1'b0;
    end else begin
      cpu_slot <= !cpu_slot;  // Toggles each clk
    end
  end

  assign vid_bank  = vram_bank_hi ? `ZX_VRAM_BANK1 : `ZX_VRAM_BANK0;
  assign sram_addr = cpu_slot ? req.addr : {vid_bank, vid_addr};

  ////////////////////////////////////////
  // Write path
  ////////////////////////////////////////
  // Arm during the video slot so WE lands in the next CPU slot
  assign wr_go = !cpu_slot && req.wr && !wr_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sram_we_n <= 1'b1;
      wr_done   <= 1'b0;
    end else begin
      sram_we_n <= !wr_go;                     // One clk pulse
      wr_done   <= req.wr && (wr_done || wr_go); // Clears when wr_n rises
    end
  end

  // Write data held steady under WE
  always_ff @(posedge clk) begin
    if (wr_go) begin
      wdata_q <= req.wdata;
    end
  end

  assign sram_data = sram_we_n ? 8'hzz : wdata_q;  // Bus released when not writing

  ////////////////////////////////////////
  // Read capture
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vid_data  <= 8'h00;
      ram_rdata <= 8'h00;
    end else if (!cpu_slot) begin
      vid_data <= sram_data;   // End of video slot
    end else if (req.rd) begin
      ram_rdata <= sram_data;  // End of CPU slot
    end
  end

  // WE only ever inside a CPU slot
  a_we_in_cpu_slot: assert property (@(posedge clk) disable iff (!rst_n)
    !sram_we_n |-> cpu_slot);

  // Never a stretched write pulse
  a_we_single: assert property (@(posedge clk) disable iff (!rst_n)
    !sram_we_n |=> sram_we_n);

endmodule

// File: logic/page_mapper.sv
`include "zxuno_settings.svh"

module page_mapper (
  input  logic                 clk,
  input  logic                 rst_n,
  input  zxuno_pkg::cpu_bus_t  bus,
  output zxuno_pkg::page_cfg_t cfg,
  output logic [14:0]          rom_addr,
  output zxuno_pkg::mem_req_t  req,
  output zxuno_pkg::cpu_src_t  src,
  output logic                 vram_bank_hi
);

  localparam logic [15:0] PORT_MASK = 16'h8002;  // A15 and A1

  logic       port_hit;
  logic       io_wr;
  logic       io_wr_q;    // Strobe seen last clk
  logic       mem_cyc;
  logic       rom_cyc;
  logic [2:0] bank;

  ////////////////////////////////////////
  // Paging register
  ////////////////////////////////////////
  assign port_hit = (bus.addr & PORT_MASK) == (`ZX_PAGE_PORT & PORT_MASK);
  assign io_wr    = !bus.iorq_n && !bus.wr_n && port_hit;

  // Loads once on the first clk of the strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      io_wr_q <= 1'b0;
      cfg     <= '0;
    end else begin
      io_wr_q <= io_wr;
      if (io_wr && !io_wr_q && !cfg.lock) begin
        cfg <= zxuno_pkg::page_cfg_t'(bus.dout[5:0]);  // Upper bits ignored
      end
    end
  end

  assign vram_bank_hi = cfg.vram_page;  // Picks bank 7 over bank 5

  ////////////////////////////////////////
  // CPU address decode
  ////////////////////////////////////////
  assign mem_cyc  = !bus.mreq_n;
  assign rom_cyc  = mem_cyc && (bus.addr[15:14] == 2'b00);  // Bottom 16 KB
  assign rom_addr = {cfg.rom_sel, bus.addr[13:0]};

  always_comb begin
    case (bus.addr[15:14])
      2'b01:   bank = `ZX_BANK_4000;
      2'b10:   bank = `ZX_BANK_8000;
      default: bank = cfg.bank;       // Paged window at 0xC000
    endcase
  end

  assign req = '{
    addr:  {bank, bus.addr[13:0]},
    rd:    mem_cyc && !rom_cyc && !bus.rd_n,
    wr:    mem_cyc && !rom_cyc && !bus.wr_n,
    wdata: bus.dout
  };

  // Read source for the return mux
  always_comb begin
    if (rom_cyc && !bus.rd_n) begin
      src = zxuno_pkg::SRC_ROM;
    end else if (req.rd) begin
      src = zxuno_pkg::SRC_RAM;
    end else begin
      src = zxuno_pkg::SRC_NONE;  // Idle or I/O read
    end
  end

  // ROM and SRAM never claim the same cycle
  a_rom_excl: assert property (@(posedge clk) disable iff (!rst_n)
    (src == zxuno_pkg::SRC_ROM) |-> !(req.rd || req.wr));

endmodule

// File: logic/zxuno_pkg.sv
`include "zxuno_settings.svh"

package zxuno_pkg;

  // Raw Z80 outputs, strobes active low
  typedef struct packed {
    logic [15:0] addr;
    logic        mreq_n;
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic [7:0]  dout;    // CPU write data
  } cpu_bus_t;

  // Port 0x7FFD image, field order matches D5..D0
  typedef struct packed {
    logic       lock;       // D5, freezes paging until reset
    logic       rom_sel;    // D4
    logic       vram_page;  // D3, shadow screen
    logic [2:0] bank;       // D2..D0, bank at 0xC000
  } page_cfg_t;

  // CPU side of the SRAM
  typedef struct packed {
    logic [`ZX_SRAM_AW-1:0] addr;
    logic                   rd;
    logic                   wr;     // Level, held for the whole strobe
    logic [7:0]             wdata;
  } mem_req_t;

  // Who answers a CPU read
  typedef enum logic [1:0] {
    SRC_NONE,  // Floating bus
    SRC_ROM,
    SRC_RAM
  } cpu_src_t;

endpackage

// File: include/zxuno_settings.svh
`ifndef ZXUNO_SETTINGS_SVH
`define ZXUNO_SETTINGS_SVH

////////////////////////////////////////
// SRAM geometry
////////////////////////////////////////
// Eight banks of 16 KB
`define ZX_SRAM_AW 17

////////////////////////////////////////
// 128K paging
////////////////////////////////////////
`define ZX_PAGE_PORT 16'h7FFD  // Only A15 and A1 take part in the decode

// Banks behind the fixed CPU windows
`define ZX_BANK_4000 3'd5
`define ZX_BANK_8000 3'd2

// Normal and shadow screen
`define ZX_VRAM_BANK0 3'd5
`define ZX_VRAM_BANK1 3'd7

`endif
